/* verilog.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_way_ram.sv
rtl/icache_victim_lfsr.sv
rtl/icache.sv
rtl/inst_predecoder.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
sim/tb_fetch_frontend.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_frontend \
        -f verilog.f -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim/tb_fetch_frontend.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_fetch_frontend;

    localparam int FW = `ICACHE_FETCH_WIDTH;
    // about 60 fetches with the worst miss under back-pressure well below 50 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                        clk = 1'b0;
    logic                        rst_n = 1'b0;
    logic [31:0]                 fetch_pc_i = '0;
    logic [FW-1:0]               fetch_valid_i = '0;
    logic                        cacheop_valid_i = 1'b0;
    icache_pkg::cacheop_e        cacheop_i = icache_pkg::HIT_INV;
    logic                        uncached_i = 1'b0;
    logic                        fetch_ready_o;
    logic                        cacheop_ready_o;
    logic                        deq_valid_o;
    icache_pkg::fetch_bundle_t   deq_bundle_o;
    logic                        deq_ready_i = 1'b1;
    logic                        bus_busy_i = 1'b0;
    icache_pkg::cache_bus_req_t  bus_req_o;
    icache_pkg::cache_bus_resp_t bus_resp_i = '0;

    integer      seed = 534;
    int          cycle_cnt = 0;
    int          stretch = 0;
    bit          stall_mode = 1'b0;
    // expected order at the queue output
    logic [31:0] exp_pc[$];
    logic [1:0]  exp_mask[$];
    // address requests seen by the bus model
    logic [31:0] req_addr[$];
    logic [1:0]  req_len[$];
    bit          req_cached[$];

    fetch_frontend u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_pc_i      (fetch_pc_i),
        .fetch_valid_i   (fetch_valid_i),
        .cacheop_valid_i (cacheop_valid_i),
        .cacheop_i       (cacheop_i),
        .uncached_i      (uncached_i),
        .fetch_ready_o   (fetch_ready_o),
        .cacheop_ready_o (cacheop_ready_o),
        .deq_valid_o     (deq_valid_o),
        .deq_bundle_o    (deq_bundle_o),
        .deq_ready_i     (deq_ready_i),
        .bus_busy_i      (bus_busy_i),
        .bus_req_o       (bus_req_o),
        .bus_resp_i      (bus_resp_i)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // memory word is the address xor a5a50000 with the top two bits from address bits 5:4
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] w;
        w = addr ^ 32'ha5a5_0000;
        w[31:30] = addr[5:4];
        return w;
    endfunction

    task automatic check(input bit cond, input string msg);
        assert (cond) else begin
            $display("Fail at time %0t: %s", $time, msg);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // compare one dequeued bundle against the oldest accepted fetch
    task automatic check_deq();
        logic [31:0] pc;
        logic [31:0] addr;
        logic [1:0]  mask;
        logic [31:0] word;
        bit          adef_exp;
        check(exp_pc.size() > 0, "a bundle was dequeued with no fetch outstanding");
        pc = exp_pc.pop_front();
        mask = exp_mask.pop_front();
        adef_exp = (pc[1:0] != 2'b00);
        check(deq_bundle_o.pc == pc,
              $sformatf("bundle pc %h, expected %h", deq_bundle_o.pc, pc));
        check(deq_bundle_o.valid == mask,
              $sformatf("pc %h mask %b, expected %b", pc, deq_bundle_o.valid, mask));
        check(deq_bundle_o.excp.adef == adef_exp,
              $sformatf("pc %h adef %b, expected %b", pc, deq_bundle_o.excp.adef, adef_exp));
        for (int i = 0; i < FW; i++) begin
            if (mask[i]) begin
                addr = pc + 32'(4 * i);
                word = adef_exp ? 32'h0 : mem_word(addr);
                check(deq_bundle_o.inst[i] == word,
                      $sformatf("pc %h word %0d is %h, expected %h",
                                pc, i, deq_bundle_o.inst[i], word));
                if (!adef_exp) begin
                    check(deq_bundle_o.cls[i] == addr[5:4],
                          $sformatf("pc %h word %0d class %0d, expected %0d",
                                    pc, i, deq_bundle_o.cls[i], addr[5:4]));
                end
            end
        end
    endtask

    // consumer side with random stretches of back-pressure when enabled
    always begin : consumer
        @(negedge clk);
        if (stall_mode) begin
            if (stretch == 0) begin
                deq_ready_i = ($random(seed) & 1) != 0;
                stretch = $random(seed) & 7;
            end else begin
                stretch = stretch - 1;
            end
        end else begin
            deq_ready_i = 1'b1;
        end
        if (rst_n && deq_valid_o && deq_ready_i) begin
            check_deq();
        end
    end

    // memory bus model
    always begin : bus_model
        int          delay;
        int          gap;
        int          beat;
        logic [31:0] addr;
        logic [1:0]  len;
        @(negedge clk);
        if (rst_n && bus_req_o.valid) begin
            bus_busy_i = 1'b0;
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            addr = bus_req_o.addr;
            len = bus_req_o.burst_len;
            req_addr.push_back(addr);
            req_len.push_back(len);
            req_cached.push_back(bus_req_o.cached);
            bus_resp_i.ready = 1'b1;
            @(negedge clk);
            bus_resp_i.ready = 1'b0;
            for (beat = 0; beat <= int'(len); beat++) begin
                gap = $random(seed) & 1;
                repeat (gap) @(negedge clk);
                check(bus_req_o.data_ok, "the cache is not taking beats during a transfer");
                bus_resp_i.data_ok = 1'b1;
                bus_resp_i.data_last = (beat == int'(len));
                bus_resp_i.r_data = mem_word(addr + 32'(4 * beat));
                @(negedge clk);
                bus_resp_i.data_ok = 1'b0;
                bus_resp_i.data_last = 1'b0;
            end
        end else begin
            bus_busy_i = ($random(seed) & 7) == 0;
        end
    end

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic issue_fetch(input logic [31:0] pc, input logic [1:0] mask, input bit unc);
        fetch_pc_i = pc;
        fetch_valid_i = mask;
        uncached_i = unc;
        #1;
        while (!fetch_ready_o) begin
            @(negedge clk);
            #1;
        end
        exp_pc.push_back(pc);
        exp_mask.push_back(mask);
        @(negedge clk);
        fetch_valid_i = '0;
    endtask

    task automatic issue_op(input logic [31:0] pc, input icache_pkg::cacheop_e op);
        fetch_pc_i = pc;
        cacheop_i = op;
        cacheop_valid_i = 1'b1;
        #1;
        while (!cacheop_ready_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        cacheop_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_pc.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_reqs(input int base, input int n, input string what);
        check(req_addr.size() == base + n,
              $sformatf("%s made %0d bus requests, expected %0d",
                        what, req_addr.size() - base, n));
    endtask

    initial begin : main
        logic [31:0] pc;
        int          base;
        int          m;
        bit          unc;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet outputs until the tag sweep is done
        while (!fetch_ready_o) begin
            check(!deq_valid_o && !bus_req_o.valid, "queue or bus active before any request");
            @(negedge clk);
        end

        // cached miss then hits on the same line
        base = req_addr.size();
        issue_fetch(32'h0000_1008, 2'b11, 1'b0);
        wait_drain();
        expect_reqs(base, 1, "cached miss");
        check(req_addr[base] == 32'h1000 && req_len[base] == 2'd3 && req_cached[base],
              $sformatf("refill addr %h len %0d, expected 1000 len 3",
                        req_addr[base], req_len[base]));
        base = req_addr.size();
        issue_fetch(32'h0000_1000, 2'b11, 1'b0);
        issue_fetch(32'h0000_1008, 2'b01, 1'b0);
        wait_drain();
        expect_reqs(base, 0, "refetch of a cached line");

        // uncached fetch twice
        repeat (2) begin
            base = req_addr.size();
            issue_fetch(32'h0000_2000, 2'b11, 1'b1);
            wait_drain();
            expect_reqs(base, 2, "uncached fetch");
            check(req_addr[base] == 32'h2000 && req_addr[base + 1] == 32'h2004
                  && req_len[base] == 2'd0 && req_len[base + 1] == 2'd0
                  && !req_cached[base] && !req_cached[base + 1],
                  $sformatf("uncached reads at %h and %h", req_addr[base], req_addr[base + 1]));
        end

        // maintenance ops
        base = req_addr.size();
        issue_fetch(32'h0000_1010, 2'b11, 1'b0);
        issue_fetch(32'h0000_1020, 2'b11, 1'b0);
        // 1100 shares set 0 with 1000
        issue_fetch(32'h0000_1100, 2'b11, 1'b0);
        wait_drain();
        expect_reqs(base, 3, "loading three more lines");
        issue_op(32'h0000_1000, icache_pkg::HIT_INV);
        // hit invalidate leaves the other way of the set alone
        base = req_addr.size();
        issue_fetch(32'h0000_1100, 2'b11, 1'b0);
        wait_drain();
        expect_reqs(base, 0, "fetch of the other line in the invalidated set");
        base = req_addr.size();
        issue_fetch(32'h0000_1000, 2'b11, 1'b0);
        wait_drain();
        expect_reqs(base, 1, "refetch after hit invalidate");
        check(req_addr[base] == 32'h1000,
              $sformatf("refill addr %h, expected 1000", req_addr[base]));
        base = req_addr.size();
        issue_fetch(32'h0000_1010, 2'b11, 1'b0);
        wait_drain();
        expect_reqs(base, 0, "fetch of an untouched line");
        // pc bit 0 picks the way so both get cleared
        issue_op(32'h0000_1020, icache_pkg::INDEX_INV);
        issue_op(32'h0000_1021, icache_pkg::INDEX_INV);
        base = req_addr.size();
        issue_fetch(32'h0000_1020, 2'b11, 1'b0);
        wait_drain();
        expect_reqs(base, 1, "refetch after index invalidate");
        check(req_addr[base] == 32'h1020,
              $sformatf("refill addr %h, expected 1020", req_addr[base]));
        base = req_addr.size();
        issue_fetch(32'h0000_1010, 2'b11, 1'b0);
        issue_fetch(32'h0000_1000, 2'b10, 1'b0);
        wait_drain();
        expect_reqs(base, 0, "fetch of lines in other sets");

        // misaligned pc
        base = req_addr.size();
        issue_fetch(32'h0000_1042, 2'b11, 1'b0);
        issue_fetch(32'h0000_3001, 2'b01, 1'b1);
        wait_drain();
        expect_reqs(base, 0, "misaligned fetch");

        // random fetches under back-pressure
        stall_mode = 1'b1;
        repeat (40) begin
            pc = 32'h0000_4000 | (32'($random(seed)) & 32'h0000_01f8);
            unc = ($random(seed) & 3) == 0;
            m = $random(seed) & 3;
            if (m == 0) begin
                m = 3;
            end
            issue_fetch(pc, 2'(m), unc);
        end
        wait_drain();
        stall_mode = 1'b0;
        repeat (10) @(negedge clk);
        check(exp_pc.size() == 0 && !deq_valid_o, "extra bundle after every fetch was dequeued");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* rtl/fetch_frontend.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module fetch_frontend (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [31:0]                     fetch_pc_i,
    input  logic [`ICACHE_FETCH_WIDTH-1:0]  fetch_valid_i,
    input  logic                            cacheop_valid_i,
    input  icache_pkg::cacheop_e            cacheop_i,
    input  logic                            uncached_i,
    output logic                            fetch_ready_o,
    output logic                            cacheop_ready_o,
    output logic                            deq_valid_o,
    output icache_pkg::fetch_bundle_t       deq_bundle_o,
    input  logic                            deq_ready_i,
    input  logic                            bus_busy_i,
    output icache_pkg::cache_bus_req_t      bus_req_o,
    input  icache_pkg::cache_bus_resp_t     bus_resp_i
);

    icache_pkg::fetch_bundle_t cache_bundle;
    icache_pkg::fetch_bundle_t pre_bundle;
    // queue room, shared by cache and predecoder
    logic                      queue_ready;

    icache u_icache (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_pc_i      (fetch_pc_i),
        .fetch_valid_i   (fetch_valid_i),
        .cacheop_valid_i (cacheop_valid_i),
        .cacheop_i       (cacheop_i),
        .uncached_i      (uncached_i),
        .fetch_ready_o   (fetch_ready_o),
        .cacheop_ready_o (cacheop_ready_o),
        .bundle_o        (cache_bundle),
        .ready_i         (queue_ready),
        .bus_busy_i      (bus_busy_i),
        .bus_req_o       (bus_req_o),
        .bus_resp_i      (bus_resp_i)
    );

    inst_predecoder u_predecoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .bundle_i (cache_bundle),
        .bundle_o (pre_bundle),
        .ready_i  (queue_ready)
    );

    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .enq_bundle_i (pre_bundle),
        .enq_ready_o  (queue_ready),
        .deq_valid_o  (deq_valid_o),
        .deq_bundle_o (deq_bundle_o),
        .deq_ready_i  (deq_ready_i)
    );

endmodule

/* rtl/fetch_queue.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module fetch_queue #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  icache_pkg::fetch_bundle_t enq_bundle_i,
    output logic                      enq_ready_o,
    output logic                      deq_valid_o,
    output icache_pkg::fetch_bundle_t deq_bundle_o,
    input  logic                      deq_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);

    icache_pkg::fetch_bundle_t mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [PTR_W:0]            count;
    logic                      push;
    logic                      pop;

    // two free slots so the predecoder register always has a home
    assign enq_ready_o  = count <= (PTR_W + 1)'(DEPTH - 2);
    assign deq_valid_o  = count != '0;
    assign deq_bundle_o = mem[rd_ptr];

    assign push = enq_ready_o && (|enq_bundle_i.valid);
    assign pop  = deq_valid_o && deq_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= enq_bundle_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/inst_predecoder.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module inst_predecoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  icache_pkg::fetch_bundle_t bundle_i,
    output icache_pkg::fetch_bundle_t bundle_o,
    input  logic                      ready_i
);

    icache_pkg::fetch_bundle_t decoded;

    // class straight from the major opcode bits
    always_comb begin
        decoded = bundle_i;
        for (int i = 0; i < `ICACHE_FETCH_WIDTH; i++) begin
            decoded.cls[i] = icache_pkg::inst_class_e'(bundle_i.inst[i][31:30]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bundle_o.valid <= '0;
        end else if (ready_i) begin
            bundle_o <= decoded;
        end
    end

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [31:0]                     fetch_pc_i,
    input  logic [`ICACHE_FETCH_WIDTH-1:0]  fetch_valid_i,
    input  logic                            cacheop_valid_i,
    input  icache_pkg::cacheop_e            cacheop_i,
    input  logic                            uncached_i,
    output logic                            fetch_ready_o,
    output logic                            cacheop_ready_o,
    output icache_pkg::fetch_bundle_t       bundle_o,
    input  logic                            ready_i,
    input  logic                            bus_busy_i,
    output icache_pkg::cache_bus_req_t      bus_req_o,
    input  icache_pkg::cache_bus_resp_t     bus_resp_i
);

    localparam int WAYS  = `ICACHE_WAYS;
    localparam int FW    = `ICACHE_FETCH_WIDTH;
    localparam int WAY_W = $clog2(WAYS);

    icache_pkg::fsm_state_e state_q;
    icache_pkg::fsm_state_e state_d;

    // stage one
    logic [31:0]          s1_pc;
    logic [FW-1:0]        s1_mask;
    logic                 s1_op;
    logic                 s1_unc;
    icache_pkg::cacheop_e s1_opcode;

    // stage two
    logic [31:0]          s2_pc;
    logic [FW-1:0]        s2_mask;
    logic                 s2_op;
    logic                 s2_unc;
    logic                 s2_done;
    icache_pkg::cacheop_e s2_opcode;

    icache_pkg::fetch_bundle_t out_q;

    logic                 clearing;
    logic [3:0]           clr_cnt;
    logic [1:0]           beat_q;
    logic [FW-1:0][31:0]  unc_buf;

    logic [5:0]                        ram_addr;
    logic [WAYS-1:0]                   data_we;
    logic [WAYS-1:0]                   tag_we;
    logic [WAYS-1:0]                   hit_way;
    icache_pkg::cache_tag_t            w_tag;
    icache_pkg::cache_tag_t [WAYS-1:0] r_tag;
    logic [WAYS-1:0][FW-1:0][31:0]     r_data;
    logic [WAY_W-1:0]                  victim;
    logic [FW-1:0][31:0]               hit_inst;

    logic hit;
    logic adef;
    logic need_bus;
    logic need_op;
    logic busy;
    logic adv;
    logic beat_ok;
    logic last_beat;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_way_ram u_way_ram (
            .clk       (clk),
            .rst_n     (rst_n),
            .addr_i    (ram_addr),
            .data_we_i (data_we[w]),
            .tag_we_i  (tag_we[w]),
            .data_i    (bus_resp_i.r_data),
            .tag_i     (w_tag),
            .data_o    (r_data[w]),
            .tag_o     (r_tag[w])
        );

        assign hit_way[w] = r_tag[w].valid && (r_tag[w].tag == s2_pc[31:8]);
    end

    icache_victim_lfsr #(
        .WAY_W (WAY_W)
    ) u_victim_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (last_beat && !s2_unc),
        .victim_o  (victim)
    );

    always_comb begin
        hit_inst = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_way[w]) begin
                hit_inst = hit_inst | r_data[w];
            end
        end
    end

    assign hit  = |hit_way;
    assign adef = (|s2_mask) && (|s2_pc[1:0]);

    // stage two decides whether the controller has to leave NORMAL
    assign need_bus = (|s2_mask) && !adef && (s2_unc || !hit) && !s2_done;
    assign need_op  = s2_op && !s2_done;
    assign busy     = clearing || (state_q != icache_pkg::NORMAL) || need_bus || need_op;
    assign adv      = ready_i && !busy;

    assign fetch_ready_o   = adv && !cacheop_valid_i;
    assign cacheop_ready_o = adv;

    assign beat_ok   = (state_q == icache_pkg::FILL) && bus_resp_i.data_ok;
    assign last_beat = beat_ok && bus_resp_i.data_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_mask     <= '0;
            s1_op       <= 1'b0;
            s2_mask     <= '0;
            s2_op       <= 1'b0;
            out_q.valid <= '0;
        end else if (adv) begin
            s1_pc     <= fetch_pc_i;
            s1_mask   <= cacheop_valid_i ? '0 : fetch_valid_i;
            s1_op     <= cacheop_valid_i;
            s1_opcode <= cacheop_i;
            s1_unc    <= uncached_i;

            s2_pc     <= s1_pc;
            s2_mask   <= s1_mask;
            s2_op     <= s1_op;
            s2_opcode <= s1_opcode;
            s2_unc    <= s1_unc;

            out_q.pc        <= s2_pc;
            out_q.valid     <= s2_mask;
            out_q.inst      <= adef ? '0 : (s2_unc ? unc_buf : hit_inst);
            out_q.excp.adef <= adef;
            for (int i = 0; i < FW; i++) begin
                out_q.cls[i] <= icache_pkg::ALU;
            end
        end
    end

    // output held back whenever the pipe is not moving
    always_comb begin
        bundle_o       = out_q;
        bundle_o.valid = out_q.valid & {FW{adv}};
    end

    // tag clear sweep after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clearing <= 1'b1;
            clr_cnt  <= '0;
        end else if (clearing) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == 4'(`ICACHE_SETS - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::NORMAL: begin
                if (!clearing && need_op) begin
                    state_d = icache_pkg::MAINT;
                end else if (!clearing && need_bus) begin
                    state_d = bus_busy_i ? icache_pkg::WAIT_BUS : icache_pkg::ADDR;
                end
            end
            icache_pkg::MAINT: state_d = icache_pkg::SYNC;
            icache_pkg::WAIT_BUS: begin
                if (!bus_busy_i) begin
                    state_d = icache_pkg::ADDR;
                end
            end
            icache_pkg::ADDR: begin
                if (bus_resp_i.ready) begin
                    state_d = icache_pkg::FILL;
                end
            end
            icache_pkg::FILL: begin
                // uncached goes back to ADDR once for the second word
                if (last_beat) begin
                    state_d = (s2_unc && !beat_q[0]) ? icache_pkg::ADDR : icache_pkg::SYNC;
                end
            end
            default: state_d = icache_pkg::NORMAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= icache_pkg::NORMAL;
            beat_q  <= '0;
            s2_done <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == icache_pkg::NORMAL) begin
                beat_q <= '0;
            end else if (beat_ok) begin
                beat_q <= beat_q + 1'b1;
            end
            if (state_q == icache_pkg::SYNC) begin
                s2_done <= 1'b1;
            end else if (adv) begin
                s2_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok && s2_unc) begin
            unc_buf[beat_q[0]] <= bus_resp_i.r_data;
        end
    end

    // ram port: sweep, fill, or the address that stage two will hold next
    always_comb begin
        ram_addr    = adv ? s1_pc[7:2] : s2_pc[7:2];
        w_tag.valid = 1'b1;
        w_tag.tag   = s2_pc[31:8];
        data_we     = '0;
        tag_we      = '0;
        if (clearing) begin
            ram_addr    = {clr_cnt, 2'b00};
            w_tag.valid = 1'b0;
            tag_we      = '1;
        end else if (state_q == icache_pkg::MAINT) begin
            w_tag.valid = 1'b0;
            if (s2_opcode == icache_pkg::INDEX_INV) begin
                tag_we[s2_pc[WAY_W-1:0]] = 1'b1;
            end else begin
                tag_we = hit_way;
            end
        end else if (state_q == icache_pkg::FILL) begin
            ram_addr = {s2_pc[7:4], beat_q};
            if (beat_ok && !s2_unc) begin
                data_we[victim] = 1'b1;
                tag_we[victim]  = 1'b1;
            end
        end
    end

    assign bus_req_o.valid     = (state_q == icache_pkg::ADDR);
    assign bus_req_o.addr      = s2_unc ? s2_pc + 32'({beat_q[0], 2'b00})
                                        : {s2_pc[31:4], 4'b0000};
    assign bus_req_o.burst_len = s2_unc ? 2'd0 : 2'(`ICACHE_LINE_WORDS - 1);
    assign bus_req_o.cached    = !s2_unc;
    assign bus_req_o.data_ok   = (state_q == icache_pkg::FILL);

endmodule

/* rtl/icache_victim_lfsr.sv */
`timescale 1ns/1ps

module icache_victim_lfsr #(
    parameter int WAY_W = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             advance_i,
    output logic [WAY_W-1:0] victim_o
);

    logic [7:0] lfsr_q;

    // galois form of x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= 8'h5a;
        end else if (advance_i) begin
            lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hb8 : 8'h00);
        end
    end

    assign victim_o = lfsr_q[WAY_W-1:0];

endmodule

/* rtl/icache_way_ram.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_way_ram (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [5:0]                          addr_i,
    input  logic                                data_we_i,
    input  logic                                tag_we_i,
    input  logic [31:0]                         data_i,
    input  icache_pkg::cache_tag_t              tag_i,
    output logic [`ICACHE_FETCH_WIDTH-1:0][31:0] data_o,
    output icache_pkg::cache_tag_t              tag_o
);

    logic [`ICACHE_LINE_WORDS-1:0][31:0] data_mem [`ICACHE_SETS];
    icache_pkg::cache_tag_t              tag_mem  [`ICACHE_SETS];
    logic [3:0]                          set_idx;

    assign set_idx = addr_i[5:2];

    always_ff @(posedge clk) begin
        if (data_we_i) begin
            data_mem[set_idx][addr_i[1:0]] <= data_i;
        end
        if (tag_we_i) begin
            tag_mem[set_idx] <= tag_i;
        end
    end

    // registered read, pair picked by pc[3]
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_o.valid <= 1'b0;
        end else begin
            tag_o <= tag_mem[set_idx];
        end
        data_o <= addr_i[1] ? data_mem[set_idx][3:2] : data_mem[set_idx][1:0];
    end

endmodule

/* rtl/icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    typedef enum logic [2:0] {
        NORMAL,
        MAINT,
        WAIT_BUS,
        ADDR,
        FILL,
        SYNC
    } fsm_state_e;

    typedef enum logic [1:0] {
        INDEX_INV = 2'b01,
        HIT_INV   = 2'b10
    } cacheop_e;

    // major opcode class from inst[31:30]
    typedef enum logic [1:0] {
        ALU    = 2'b00,
        MEM    = 2'b01,
        BRANCH = 2'b10,
        JUMP   = 2'b11
    } inst_class_e;

    typedef struct packed {
        logic        valid;
        logic [23:0] tag;
    } cache_tag_t;

    typedef struct packed {
        logic adef;
    } fetch_excp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        // beats minus one
        logic [1:0]  burst_len;
        logic        cached;
        logic        data_ok;
    } cache_bus_req_t;

    typedef struct packed {
        logic        ready;
        logic        data_ok;
        logic        data_last;
        logic [31:0] r_data;
    } cache_bus_resp_t;

    typedef struct packed {
        logic [31:0]                                pc;
        logic [`ICACHE_FETCH_WIDTH-1:0]             valid;
        logic [`ICACHE_FETCH_WIDTH-1:0][31:0]       inst;
        inst_class_e [`ICACHE_FETCH_WIDTH-1:0]      cls;
        fetch_excp_t                                excp;
    } fetch_bundle_t;

endpackage

/* rtl/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// instruction words returned per fetch
`define ICACHE_FETCH_WIDTH 2
`define ICACHE_WAYS 2
// index is pc[7:4], tag is pc[31:8]
`define ICACHE_SETS 16
// words per line, also the refill burst length
`define ICACHE_LINE_WORDS 4
`define FETCH_QUEUE_DEPTH 4

`endif
